/* ai_accel_pkg.sv */
// Command opcodes and data width shared by the accelerator RTL and its testbench.
package ai_accel_pkg;

    // Width of every operand, product and accumulated result.
    parameter int DATA_W = 32;

    // Opcodes the host drives on cmd_i. A command takes effect only while start_i is high.
    typedef enum logic [2:0] {
        CMD_NOP     = 3'd0, // Idle. done_o stays high.
        CMD_LOAD_W  = 3'd1, // Write one or two weights.
        CMD_CLEAR_W = 3'd2, // Zero the weight buffer and its pointers.
        CMD_LOAD_X  = 3'd3, // Write one or two inputs.
        CMD_CLEAR_X = 3'd4, // Zero the input buffer and its pointers.
        CMD_RUN     = 3'd5  // Stream both buffers through the MAC.
    } accel_cmd_e;

endpackage

/* operand_buffer.sv */
// Circular operand store that takes one or two words per cycle and feeds one word per read to the MAC.
`timescale 1ns/10ps

module operand_buffer #(
    parameter int DEPTH = 16
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            clear_i,
    input  logic                            write1_en_i,
    input  logic                            write2_en_i,
    input  logic [ai_accel_pkg::DATA_W-1:0] write1_data_i,
    input  logic [ai_accel_pkg::DATA_W-1:0] write2_data_i,
    input  logic                            read_en_i,
    output logic [ai_accel_pkg::DATA_W-1:0] read_data_o
);
    import ai_accel_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr_next; // Slot that takes the second word of a pair.

    assign wr_ptr_next = wr_ptr + PTR_W'(1);

    // Reads are combinational so the MAC sees the entry in the same cycle.
    assign read_data_o = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (write1_en_i) begin
                mem[wr_ptr] <= write1_data_i;
                if (write2_en_i) begin
                    mem[wr_ptr_next] <= write2_data_i;
                    wr_ptr           <= wr_ptr + PTR_W'(2); // Pair load.
                end else begin
                    wr_ptr <= wr_ptr_next;
                end
            end
            // Pointers are log2(DEPTH) wide, so both wrap modulo DEPTH on their own.
            if (read_en_i) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
        end
    end

endmodule

/* accel_control.sv */
// Command decoder that turns cmd_i and start_i into buffer strobes and times the RUN sequence.
`timescale 1ns/10ps

module accel_control #(
    parameter int DEPTH = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  ai_accel_pkg::accel_cmd_e cmd_i,
    input  logic                     start_i,
    input  logic                     rs2_en_i,
    output logic                     done_o,
    output logic                     write1_x_o,
    output logic                     write2_x_o,
    output logic                     write1_w_o,
    output logic                     write2_w_o,
    output logic                     clear_x_o,
    output logic                     clear_w_o,
    output logic                     read_en_o,
    output logic                     acc_clear_o
);
    import ai_accel_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    logic [PTR_W-1:0] run_cnt;
    logic             run_last;

    // The counter follows cmd_i alone, so start_i only qualifies the reads.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run_cnt <= '0;
        end else if (cmd_i == CMD_RUN) begin
            run_cnt <= run_cnt + PTR_W'(1);
        end else begin
            run_cnt <= '0;
        end
    end

    assign run_last = (run_cnt == PTR_W'(DEPTH - 1));
    assign done_o   = (cmd_i != CMD_RUN) || run_last;

    always_comb begin
        write1_x_o = 1'b0;
        write2_x_o = 1'b0;
        write1_w_o = 1'b0;
        write2_w_o = 1'b0;
        clear_x_o  = 1'b0;
        clear_w_o  = 1'b0;
        read_en_o  = 1'b0;
        if (start_i) begin
            case (cmd_i)
                CMD_LOAD_W: begin
                    write1_w_o = 1'b1;
                    write2_w_o = rs2_en_i; // Second word rides on rs2.
                end
                CMD_CLEAR_W: clear_w_o = 1'b1;
                CMD_LOAD_X: begin
                    write1_x_o = 1'b1;
                    write2_x_o = rs2_en_i;
                end
                CMD_CLEAR_X: clear_x_o = 1'b1;
                CMD_RUN:     read_en_o = 1'b1;
                default:     ;
            endcase
        end
    end

    // The first read of a run restarts the accumulator.
    assign acc_clear_o = read_en_o && (run_cnt == '0);

endmodule

/* mac_unit.sv */
// Multiply-accumulate stage that sums the products of the input and weight streams during RUN.
`timescale 1ns/10ps

module mac_unit (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            en_i,
    input  logic                            clear_i,
    input  logic [ai_accel_pkg::DATA_W-1:0] a_i,
    input  logic [ai_accel_pkg::DATA_W-1:0] b_i,
    output logic [ai_accel_pkg::DATA_W-1:0] acc_o
);
    import ai_accel_pkg::*;

    logic [2*DATA_W-1:0] product_full;
    logic [DATA_W-1:0]   product;
    logic [DATA_W-1:0]   acc;

    // Operands are unsigned and only the low word of each product is kept.
    assign product_full = a_i * b_i;
    assign product      = product_full[DATA_W-1:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            acc <= '0;
        end else if (en_i) begin
            if (clear_i) begin
                acc <= product; // First pair of a run.
            end else begin
                acc <= acc + product; // Sum wraps at DATA_W bits.
            end
        end
    end

    // The accumulator holds its value between runs, so it doubles as the result register.
    assign acc_o = acc;

endmodule

/* ai_accel_top.sv */
// Top level of the dot-product accelerator, wiring control, the two operand buffers and the MAC.
`timescale 1ns/10ps

module ai_accel_top #(
    parameter int DEPTH = 16
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  ai_accel_pkg::accel_cmd_e        cmd_i,
    input  logic                            start_i,
    input  logic                            rs2_en_i,
    input  logic [ai_accel_pkg::DATA_W-1:0] value1_i,
    input  logic [ai_accel_pkg::DATA_W-1:0] value2_i,
    output logic                            done_o,
    output logic [ai_accel_pkg::DATA_W-1:0] result_o
);
    import ai_accel_pkg::*;

    logic              write1_x;
    logic              write2_x;
    logic              write1_w;
    logic              write2_w;
    logic              clear_x;
    logic              clear_w;
    logic              read_en;
    logic              acc_clear;
    logic [DATA_W-1:0] x_data;
    logic [DATA_W-1:0] w_data;

    accel_control #(
        .DEPTH (DEPTH)
    ) i_control (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_i       (cmd_i),
        .start_i     (start_i),
        .rs2_en_i    (rs2_en_i),
        .done_o      (done_o),
        .write1_x_o  (write1_x),
        .write2_x_o  (write2_x),
        .write1_w_o  (write1_w),
        .write2_w_o  (write2_w),
        .clear_x_o   (clear_x),
        .clear_w_o   (clear_w),
        .read_en_o   (read_en),
        .acc_clear_o (acc_clear)
    );

    // Both buffers see the same load data; the strobes pick the target.
    operand_buffer #(
        .DEPTH (DEPTH)
    ) i_x_buf (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .clear_i       (clear_x),
        .write1_en_i   (write1_x),
        .write2_en_i   (write2_x),
        .write1_data_i (value1_i),
        .write2_data_i (value2_i),
        .read_en_i     (read_en),
        .read_data_o   (x_data)
    );

    operand_buffer #(
        .DEPTH (DEPTH)
    ) i_w_buf (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .clear_i       (clear_w),
        .write1_en_i   (write1_w),
        .write2_en_i   (write2_w),
        .write1_data_i (value1_i),
        .write2_data_i (value2_i),
        .read_en_i     (read_en),
        .read_data_o   (w_data)
    );

    mac_unit i_mac (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .en_i    (read_en),
        .clear_i (acc_clear),
        .a_i     (x_data),
        .b_i     (w_data),
        .acc_o   (result_o)
    );

endmodule

/* ai_accel_assertions.sv */
// Concurrent checks on the control strobes and done timing, bound into every accel_control instance.
`timescale 1ns/10ps

module ai_accel_assertions (
    input logic                     clk_i,
    input logic                     rst_i,
    input ai_accel_pkg::accel_cmd_e cmd_i,
    input logic                     done_o,
    input logic                     write1_x_o,
    input logic                     write2_x_o,
    input logic                     write1_w_o,
    input logic                     write2_w_o,
    input logic                     clear_x_o,
    input logic                     clear_w_o,
    input logic                     read_en_o,
    input logic                     acc_clear_o
);
    import ai_accel_pkg::*;

    logic [4:0] groups; // One bit per write, clear or read group.

    assign groups = {write1_x_o | write2_x_o, write1_w_o | write2_w_o,
                     clear_x_o, clear_w_o, read_en_o};

    assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(groups))
        else $error("More than one strobe group active: %b", groups);

    assert property (@(posedge clk_i) disable iff (rst_i) (cmd_i != CMD_RUN) |-> done_o)
        else $error("done_o low while cmd_i is not RUN");

    assert property (@(posedge clk_i) disable iff (rst_i) acc_clear_o |-> read_en_o)
        else $error("acc_clear_o without read_en_o");

endmodule

bind accel_control ai_accel_assertions i_assertions (.*);

/* tb_ai_accel.sv */
// Testbench for the dot-product accelerator; replays the golden record file and checks done_o and result_o.
`timescale 1ns/10ps

module tb_ai_accel;
    import ai_accel_pkg::*;

    localparam int DEPTH       = 16;
    localparam int HALF_PERIOD = 20;
    localparam int SETTLE      = 10; // Sample point after a falling-edge drive.
    localparam int RUN_TIMEOUT = 4 * DEPTH;
    localparam int MAX_LINES   = 1000;

    logic              clk_i;
    logic              rst_i;
    accel_cmd_e        cmd_i;
    logic              start_i;
    logic              rs2_en_i;
    logic [DATA_W-1:0] value1_i;
    logic [DATA_W-1:0] value2_i;
    logic              done_o;
    logic [DATA_W-1:0] result_o;

    int error_count;
    int check_count;
    int timeout_count;

    ai_accel_top #(
        .DEPTH (DEPTH)
    ) i_dut (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .cmd_i    (cmd_i),
        .start_i  (start_i),
        .rs2_en_i (rs2_en_i),
        .value1_i (value1_i),
        .value2_i (value2_i),
        .done_o   (done_o),
        .result_o (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #HALF_PERIOD clk_i = ~clk_i;
    end

    // Drives one record at a falling edge and returns at a later falling edge.
    task automatic apply_record(
        input logic [8*24-1:0] name,
        input logic [31:0]     cmd,
        input logic [31:0]     start,
        input logic [31:0]     rs2,
        input logic [31:0]     v1,
        input logic [31:0]     v2,
        input logic [31:0]     exp_done,
        input logic [31:0]     check,
        input logic [31:0]     exp_result
    );
        int cycles;
        cmd_i    = accel_cmd_e'(cmd[2:0]);
        start_i  = start[0];
        rs2_en_i = rs2[0];
        value1_i = v1;
        value2_i = v2;
        #SETTLE;
        if (cmd_i == CMD_RUN) begin
            cycles = 0;
            while (done_o !== 1'b1 && cycles < RUN_TIMEOUT) begin
                @(negedge clk_i);
                #SETTLE;
                cycles++;
            end
            if (done_o !== 1'b1) begin
                $display("Timeout: done_o never rose during RUN in test %0s", name);
                timeout_count++;
                @(negedge clk_i);
            end else begin
                // Done rises in the cycle of the last read, at count DEPTH-1.
                check_count++;
                if (cycles != DEPTH - 1) begin
                    $display("Error: %0s cycles to done expected %0d actual %0d",
                             name, DEPTH - 1, cycles);
                    error_count++;
                end
                @(negedge clk_i); // The edge ending the done cycle adds the last product.
                if (check[0]) begin
                    check_count++;
                    if (result_o !== exp_result) begin
                        $display("Error: %0s result_o expected %h actual %h",
                                 name, exp_result, result_o);
                        error_count++;
                    end
                end
            end
        end else begin
            if (check[0]) begin
                check_count++;
                if (done_o !== exp_done[0]) begin
                    $display("Error: %0s done_o expected %0d actual %0d",
                             name, exp_done[0], done_o);
                    error_count++;
                end
            end
            @(negedge clk_i);
        end
    endtask

    initial begin
        logic [8*160-1:0] line_buf;
        logic [8*24-1:0]  name;
        logic [31:0]      cmd_val, start_val, rs2_val, v1, v2, done_val, check_val, result_val;
        int               fd;
        int               status;
        int               fields;
        int               line_count;
        error_count   = 0;
        check_count   = 0;
        timeout_count = 0;
        rst_i    = 1'b1;
        cmd_i    = CMD_NOP;
        start_i  = 1'b0;
        rs2_en_i = 1'b0;
        value1_i = '0;
        value2_i = '0;
        repeat (3) @(negedge clk_i);
        rst_i = 1'b0;

        fd = $fopen("ai_accel_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file ai_accel_golden.txt");
            error_count++;
        end else begin
            line_count = 0;
            while (!$feof(fd) && line_count < MAX_LINES) begin
                line_buf = '0;
                status   = $fgets(line_buf, fd);
                line_count++;
                // Comment and blank lines do not yield all nine fields.
                fields = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h", name, cmd_val,
                                 start_val, rs2_val, v1, v2, done_val, check_val, result_val);
                if (status > 0 && fields == 9) begin
                    apply_record(name, cmd_val, start_val, rs2_val, v1, v2,
                                 done_val, check_val, result_val);
                end
            end
            $fclose(fd);
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* ai_accel_golden.txt */
# name cmd start rs2_en value1 value2 exp_done check exp_result (hex; cmd 0 NOP 1 LOAD_W 2 CLEAR_W 3 LOAD_X 4 CLEAR_X 5 RUN)
# RUN records compare result_o with exp_result after done_o; other records compare done_o when check is 1.
reset_nop  0 0 0 00000000 00000000 1 1 00000000
run_empty  5 1 0 00000000 00000000 1 1 00000000
pair_w     1 1 1 00000001 00000002 1 1 00000000
pair_w     1 1 1 00000003 00000004 1 1 00000000
pair_w     1 1 1 00000005 00000006 1 1 00000000
pair_w     1 1 1 00000007 00000008 1 1 00000000
pair_w     1 1 1 00000009 0000000a 1 1 00000000
pair_w     1 1 1 0000000b 0000000c 1 1 00000000
pair_w     1 1 1 0000000d 0000000e 1 1 00000000
pair_w     1 1 1 0000000f 00000010 1 1 00000000
pair_x     3 1 1 00000010 00000020 1 1 00000000
pair_x     3 1 1 00000030 00000040 1 1 00000000
pair_x     3 1 1 00000050 00000060 1 1 00000000
pair_x     3 1 1 00000070 00000080 1 1 00000000
pair_x     3 1 1 00000090 000000a0 1 1 00000000
pair_x     3 1 1 000000b0 000000c0 1 1 00000000
pair_x     3 1 1 000000d0 000000e0 1 1 00000000
pair_x     3 1 1 000000f0 ffffffff 1 1 00000000
run_pair   5 1 0 00000000 00000000 1 1 00004d70
clear_x    4 1 0 00000000 00000000 1 1 00000000
single_x   3 1 0 00000001 0000bad0 1 1 00000000
single_x   3 1 0 00000002 0000bad0 1 1 00000000
single_x   3 1 0 00000003 0000bad0 1 1 00000000
single_x   3 1 0 00000004 0000bad0 1 1 00000000
single_x   3 1 0 00000005 0000bad0 1 1 00000000
single_x   3 1 0 00000006 0000bad0 1 1 00000000
single_x   3 1 0 00000007 0000bad0 1 1 00000000
single_x   3 1 0 00000008 0000bad0 1 1 00000000
single_x   3 1 0 00000009 0000bad0 1 1 00000000
single_x   3 1 0 0000000a 0000bad0 1 1 00000000
single_x   3 1 0 0000000b 0000bad0 1 1 00000000
single_x   3 1 0 0000000c 0000bad0 1 1 00000000
single_x   3 1 0 0000000d 0000bad0 1 1 00000000
single_x   3 1 0 0000000e 0000bad0 1 1 00000000
single_x   3 1 0 0000000f 0000bad0 1 1 00000000
single_x   3 1 0 00000010 0000bad0 1 1 00000000
run_single 5 1 0 00000000 00000000 1 1 000005d8
run_repeat 5 1 0 00000000 00000000 1 1 000005d8
clear_w    2 1 0 00000000 00000000 1 1 00000000
run_no_w   5 1 0 00000000 00000000 1 1 00000000
reload_w   1 1 1 00000010 0000000f 1 1 00000000
reload_w   1 1 1 0000000e 0000000d 1 1 00000000
reload_w   1 1 1 0000000c 0000000b 1 1 00000000
reload_w   1 1 1 0000000a 00000009 1 1 00000000
reload_w   1 1 1 00000008 00000007 1 1 00000000
reload_w   1 1 1 00000006 00000005 1 1 00000000
reload_w   1 1 1 00000004 00000003 1 1 00000000
reload_w   1 1 1 00000002 80000000 1 1 00000000
run_reload 5 1 0 00000000 00000000 1 1 00000320
final_nop  0 0 0 00000000 00000000 1 1 00000000

/* verilog.f */
ai_accel_pkg.sv
operand_buffer.sv
accel_control.sv
mac_unit.sv
ai_accel_top.sv
ai_accel_assertions.sv
tb_ai_accel.sv

/* run.sh */
#!/bin/sh
# Builds the accelerator testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_ai_accel -o Vtb_ai_accel -f verilog.f

out=$(./obj_dir/Vtb_ai_accel 2>&1) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -q "^TESTS PASSED$"; then
    exit 0
else
    exit 1
fi
